// ==== systolic_pkg.sv ====
package systolic_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    // Operand byte, fixed by the immediate field
    localparam int DATA_W = 8;
    // Lane field, enough for an 8x8 grid
    localparam int LANE_W = 3;

    // ======================================================================
    // Instruction word
    // ======================================================================

    typedef struct packed {
        logic        load_left;     // 31
        logic        load_top;      // 30
        logic        swap_left;     // 29
        logic        swap_top;      // 28
        logic        shift_right;   // 27
        logic        shift_down;    // 26
        logic        acc_en;        // 25
        logic [2:0]  reserved_hi;   // 24:22
        logic        acc_clr;       // 21
        logic [2:0]  reserved_lo;   // 20:18
        logic [4:0]  lane;          // 17:13
        logic [12:0] imm;           // 12:0, byte in 7:0
    } instr_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PREFETCH,
        SEQ_EXEC
    } seq_state_t;

    // ======================================================================
    // Control bundles
    // ======================================================================

    typedef struct packed {
        logic              load;
        logic              swap;
        logic [LANE_W-1:0] lane;
        logic [DATA_W-1:0] data;
    } buf_cmd_t;

    typedef struct packed {
        logic shift_right;
        logic shift_down;
        logic acc_en;
        logic acc_clr;
    } array_ctrl_t;

endpackage

// ==== uart_bit_timer.sv ====
`timescale 1ns/1ps

module uart_bit_timer #(
    parameter int CLK_PER_BIT = 54
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    input  logic half,
    output logic tick
);

    localparam int CNT_W = $clog2(CLK_PER_BIT + 1);
    localparam int HALF_BIT = (CLK_PER_BIT / 2 > 0) ? CLK_PER_BIT / 2 : 1;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] limit;

    // Terminal count for the requested interval
    assign limit = half ? CNT_W'(HALF_BIT - 1) : CNT_W'(CLK_PER_BIT - 1);
    assign tick  = run && (cnt == limit);

    always_ff @(posedge clk) begin
        if (rst || !run || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx import systolic_pkg::*; #(
    parameter int CLK_PER_BIT = 54
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    output logic [DATA_W-1:0] rx_byte,
    output logic              rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  rx_state;
    logic       rx_meta;
    logic       rx_sync;
    logic [2:0] bit_idx;
    logic       tick;

    // Line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    uart_bit_timer #(
        .CLK_PER_BIT(CLK_PER_BIT)
    ) u_timer (
        .clk (clk),
        .rst (rst),
        .run (rx_state != RX_IDLE),
        .half(rx_state == RX_START),
        .tick(tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= RX_IDLE;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    if (!rx_sync) rx_state <= RX_START;
                end
                RX_START: begin
                    // Mid start bit, still low or it was a glitch
                    if (tick) begin
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                        bit_idx  <= '0;
                    end
                end
                RX_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) rx_state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (tick) begin
                        rx_valid <= rx_sync;
                        rx_state <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    // Data shift register, LSB arrives first
    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && tick) begin
            rx_byte <= {rx_sync, rx_byte[DATA_W-1:1]};
        end
    end

    a_rx_valid_single: assert property (@(posedge clk) disable iff (rst)
        rx_valid |=> !rx_valid)
        else $error("uart_rx: rx_valid held for two cycles");

endmodule

// ==== instr_store.sv ====
`timescale 1ns/1ps

module instr_store import systolic_pkg::*; #(
    parameter int INSTR_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [DATA_W-1:0]              rx_byte,
    input  logic                           rx_valid,
    input  logic [$clog2(INSTR_DEPTH)-1:0] rd_addr,
    output instr_t                         rd_data
);

    localparam int ADDR_W = $clog2(INSTR_DEPTH);

    logic [1:0]          byte_cnt;
    logic [3*DATA_W-1:0] shift_reg;
    logic [4*DATA_W-1:0] wr_data;
    logic                wr_en;
    logic [ADDR_W-1:0]   wr_addr;
    instr_t              mem [INSTR_DEPTH];

    // Word assembly, first byte ends up in bits 31:24
    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt <= '0;
            wr_en    <= 1'b0;
            wr_addr  <= '0;
        end else begin
            wr_en <= 1'b0;
            if (wr_en) wr_addr <= wr_addr + 1'b1;
            if (rx_valid) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == 2'd3) wr_en <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            shift_reg <= {shift_reg[2*DATA_W-1:0], rx_byte};
            if (byte_cnt == 2'd3) wr_data <= {shift_reg, rx_byte};
        end
    end

    // Single write port, registered read
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= instr_t'(wr_data);
        rd_data <= mem[rd_addr];
    end

    a_wr_en_single: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en)
        else $error("instr_store: wr_en high on consecutive cycles");

endmodule

// ==== step_sequencer.sv ====
`timescale 1ns/1ps

module step_sequencer import systolic_pkg::*; #(
    parameter int INSTR_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           step,
    input  instr_t                         rd_data,
    output logic [$clog2(INSTR_DEPTH)-1:0] pc,
    output seq_state_t                     state,
    output instr_t                         curr_instr,
    output buf_cmd_t                       left_cmd,
    output buf_cmd_t                       top_cmd,
    output array_ctrl_t                    ctrl
);

    instr_t next_instr;

    // ======================================================================
    // Fetch and execute
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            pc         <= '0;
            curr_instr <= '0;
            next_instr <= '0;
            left_cmd   <= '0;
            top_cmd    <= '0;
            ctrl       <= '0;
        end else begin
            // Pulses last one cycle
            left_cmd.load <= 1'b0;
            left_cmd.swap <= 1'b0;
            top_cmd.load  <= 1'b0;
            top_cmd.swap  <= 1'b0;
            ctrl          <= '0;

            if (step) begin
                // Every step fetches the word at pc
                next_instr <= rd_data;
                pc         <= pc + 1'b1;
                case (state)
                    SEQ_IDLE: begin
                        state <= SEQ_PREFETCH;
                    end
                    SEQ_PREFETCH: begin
                        curr_instr <= next_instr;
                        state      <= SEQ_EXEC;
                    end
                    SEQ_EXEC: begin
                        curr_instr <= next_instr;
                        // Execute the instruction being retired
                        left_cmd <= '{load: curr_instr.load_left,
                                      swap: curr_instr.swap_left,
                                      lane: curr_instr.lane[LANE_W-1:0],
                                      data: curr_instr.imm[DATA_W-1:0]};
                        top_cmd  <= '{load: curr_instr.load_top,
                                      swap: curr_instr.swap_top,
                                      lane: curr_instr.lane[LANE_W-1:0],
                                      data: curr_instr.imm[DATA_W-1:0]};
                        ctrl     <= '{shift_right: curr_instr.shift_right,
                                      shift_down:  curr_instr.shift_down,
                                      acc_en:      curr_instr.acc_en,
                                      acc_clr:     curr_instr.acc_clr};
                    end
                    default: begin
                        state <= SEQ_IDLE;
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================

    a_pulse_after_exec_step: assert property (@(posedge clk) disable iff (rst)
        (left_cmd.load || left_cmd.swap || top_cmd.load || top_cmd.swap
         || (ctrl != '0))
        |-> $past(step && state == SEQ_EXEC))
        else $error("step_sequencer: control pulse without an executing step");

endmodule

// ==== operand_buffer.sv ====
`timescale 1ns/1ps

module operand_buffer import systolic_pkg::*; #(
    parameter int MATRIX_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  buf_cmd_t                      cmd,
    output logic [MATRIX_SIZE*DATA_W-1:0] lanes
);

    localparam int IDX_W = (MATRIX_SIZE > 1) ? $clog2(MATRIX_SIZE) : 1;

    logic [DATA_W-1:0] bank [2][MATRIX_SIZE];
    logic              active_sel;
    logic [IDX_W-1:0]  lane_idx;

    // Only the low lane bits matter for this grid size
    assign lane_idx = cmd.lane[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            active_sel <= 1'b0;
            for (int i = 0; i < MATRIX_SIZE; i++) begin
                bank[0][i] <= '0;
                bank[1][i] <= '0;
            end
        end else begin
            if (cmd.swap) active_sel <= ~active_sel;
            // Loads always land in the hidden bank
            if (cmd.load && int'(lane_idx) < MATRIX_SIZE) begin
                bank[~active_sel][lane_idx] <= cmd.data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < MATRIX_SIZE; i++) begin
            lanes[i*DATA_W +: DATA_W] = bank[active_sel][i];
        end
    end

endmodule

// ==== mac_cell.sv ====
`timescale 1ns/1ps

module mac_cell import systolic_pkg::*; #(
    parameter int ACC_WIDTH = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    input  array_ctrl_t                 ctrl,
    input  logic [DATA_W-1:0]           in_left,
    input  logic [DATA_W-1:0]           in_top,
    output logic [DATA_W-1:0]           out_right,
    output logic [DATA_W-1:0]           out_bottom,
    output logic signed [ACC_WIDTH-1:0] acc
);

    logic signed [2*DATA_W-1:0] prod;

    // Both operands are two's complement bytes
    assign prod = $signed(in_left) * $signed(in_top);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            out_right  <= '0;
            out_bottom <= '0;
        end else begin
            if (ctrl.acc_clr) begin
                acc <= '0;
            end else if (ctrl.acc_en) begin
                acc <= acc + prod;
            end
            if (ctrl.shift_right) out_right  <= in_left;
            if (ctrl.shift_down)  out_bottom <= in_top;
        end
    end

endmodule

// ==== mac_array.sv ====
`timescale 1ns/1ps

module mac_array import systolic_pkg::*; #(
    parameter int MATRIX_SIZE = 4,
    parameter int ACC_WIDTH   = 32
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  array_ctrl_t                                ctrl,
    input  logic [MATRIX_SIZE*DATA_W-1:0]              left_lanes,
    input  logic [MATRIX_SIZE*DATA_W-1:0]              top_lanes,
    input  logic [$clog2(MATRIX_SIZE*MATRIX_SIZE)-1:0] acc_sel,
    output logic [ACC_WIDTH-1:0]                       acc_out
);

    logic [DATA_W-1:0]    right_w  [MATRIX_SIZE][MATRIX_SIZE];
    logic [DATA_W-1:0]    bottom_w [MATRIX_SIZE][MATRIX_SIZE];
    logic [ACC_WIDTH-1:0] acc_w    [MATRIX_SIZE*MATRIX_SIZE];

    // ======================================================================
    // Grid
    // ======================================================================

    for (genvar i = 0; i < MATRIX_SIZE; i++) begin : g_row
        for (genvar j = 0; j < MATRIX_SIZE; j++) begin : g_col
            logic [DATA_W-1:0] cell_left;
            logic [DATA_W-1:0] cell_top;

            // Edge cells read the buffers, inner cells their neighbours
            if (j == 0) begin : g_left_edge
                assign cell_left = left_lanes[i*DATA_W +: DATA_W];
            end else begin : g_left_inner
                assign cell_left = right_w[i][j-1];
            end
            if (i == 0) begin : g_top_edge
                assign cell_top = top_lanes[j*DATA_W +: DATA_W];
            end else begin : g_top_inner
                assign cell_top = bottom_w[i-1][j];
            end

            mac_cell #(
                .ACC_WIDTH(ACC_WIDTH)
            ) u_cell (
                .clk       (clk),
                .rst       (rst),
                .ctrl      (ctrl),
                .in_left   (cell_left),
                .in_top    (cell_top),
                .out_right (right_w[i][j]),
                .out_bottom(bottom_w[i][j]),
                .acc       (acc_w[i*MATRIX_SIZE+j])
            );
        end
    end

    // Row-major select
    assign acc_out = acc_w[acc_sel];

endmodule

// ==== systolic_top.sv ====
`timescale 1ns/1ps

module systolic_top import systolic_pkg::*; #(
    parameter int MATRIX_SIZE = 4,
    parameter int ACC_WIDTH   = 32,
    parameter int CLK_PER_BIT = 54,
    parameter int INSTR_DEPTH = 256
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       uart_rx,
    input  logic                                       step,
    input  logic [$clog2(MATRIX_SIZE*MATRIX_SIZE)-1:0] acc_sel,
    output logic [ACC_WIDTH-1:0]                       acc_out,
    output logic [$clog2(INSTR_DEPTH)-1:0]             pc,
    output seq_state_t                                 state,
    output instr_t                                     curr_instr
);

    logic [DATA_W-1:0]             rx_byte;
    logic                          rx_valid;
    instr_t                        rd_data;
    buf_cmd_t                      left_cmd;
    buf_cmd_t                      top_cmd;
    array_ctrl_t                   ctrl;
    logic [MATRIX_SIZE*DATA_W-1:0] left_lanes;
    logic [MATRIX_SIZE*DATA_W-1:0] top_lanes;

    // ======================================================================
    // Instruction path
    // ======================================================================

    uart_rx #(
        .CLK_PER_BIT(CLK_PER_BIT)
    ) u_rx (
        .clk     (clk),
        .rst     (rst),
        .rx      (uart_rx),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid)
    );

    instr_store #(
        .INSTR_DEPTH(INSTR_DEPTH)
    ) u_store (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .rx_valid(rx_valid),
        .rd_addr (pc),
        .rd_data (rd_data)
    );

    step_sequencer #(
        .INSTR_DEPTH(INSTR_DEPTH)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .step      (step),
        .rd_data   (rd_data),
        .pc        (pc),
        .state     (state),
        .curr_instr(curr_instr),
        .left_cmd  (left_cmd),
        .top_cmd   (top_cmd),
        .ctrl      (ctrl)
    );

    // ======================================================================
    // Compute path
    // ======================================================================

    operand_buffer #(
        .MATRIX_SIZE(MATRIX_SIZE)
    ) left_buf (
        .clk  (clk),
        .rst  (rst),
        .cmd  (left_cmd),
        .lanes(left_lanes)
    );

    operand_buffer #(
        .MATRIX_SIZE(MATRIX_SIZE)
    ) top_buf (
        .clk  (clk),
        .rst  (rst),
        .cmd  (top_cmd),
        .lanes(top_lanes)
    );

    mac_array #(
        .MATRIX_SIZE(MATRIX_SIZE),
        .ACC_WIDTH  (ACC_WIDTH)
    ) u_array (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .left_lanes(left_lanes),
        .top_lanes (top_lanes),
        .acc_sel   (acc_sel),
        .acc_out   (acc_out)
    );

endmodule

// ==== tb_systolic_top.sv ====
`timescale 1ns/1ps

module tb_systolic_top
    import systolic_pkg::*;
();

    localparam int N            = 4;
    localparam int ACC_W        = 32;
    localparam int BIT_CYC      = 8;
    localparam int DEPTH        = 64;
    localparam int SEL_W        = $clog2(N * N);
    localparam int PC_W         = $clog2(DEPTH);
    localparam int PROG_A_WORDS = 12;
    localparam int PROG_B_WORDS = 28;
    localparam int ALL_WORDS    = PROG_A_WORDS + PROG_B_WORDS;
    // UART bytes, then four cycles per step, then room for readout and resets
    localparam int LIMIT_CYCLES = 4 * ALL_WORDS * 10 * BIT_CYC + (ALL_WORDS + 2) * 4 + 3000;
    localparam int STORE_WAIT   = 400;

    // Operands of the directed program
    localparam int A_LEFT = -7;
    localparam int A_TOP  = 11;
    localparam int A_PROD = A_LEFT * A_TOP;

    // Flag order is load_left load_top swap_left swap_top shift_right shift_down acc_en
    localparam logic [6:0] FL_LOAD_L = 7'b100_0000;
    localparam logic [6:0] FL_LOAD_T = 7'b010_0000;
    localparam logic [6:0] FL_SWAP   = 7'b001_1000;
    localparam logic [6:0] FL_SHIFT  = 7'b000_0110;
    localparam logic [6:0] FL_ACC    = 7'b000_0001;

    logic             clk;
    logic             rst;
    logic             uart_rx;
    logic             step;
    logic [SEL_W-1:0] acc_sel;
    logic [ACC_W-1:0] acc_out;
    logic [PC_W-1:0]  pc;
    seq_state_t       state;
    instr_t           curr_instr;

    int     error_count;
    int     check_count;
    int     seed;
    instr_t prog [$];

    // Values from the previous cycle
    logic [PC_W-1:0] pc_prev;
    seq_state_t      state_prev;

    // Reference model state
    logic [DATA_W-1:0] lbank [2][N];
    logic [DATA_W-1:0] tbank [2][N];
    logic              lsel;
    logic              tsel;
    logic [DATA_W-1:0] mr [N][N];
    logic [DATA_W-1:0] mb [N][N];
    int                macc [N*N];

    systolic_top #(
        .MATRIX_SIZE(N),
        .ACC_WIDTH  (ACC_W),
        .CLK_PER_BIT(BIT_CYC),
        .INSTR_DEPTH(DEPTH)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .uart_rx   (uart_rx),
        .step      (step),
        .acc_sel   (acc_sel),
        .acc_out   (acc_out),
        .pc        (pc),
        .state     (state),
        .curr_instr(curr_instr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        pc_prev    <= pc;
        state_prev <= state;
    end

    // ======================================================================
    // Sequencer properties
    // ======================================================================

    a_idle_step: assert property (@(posedge clk) disable iff (rst)
        step && state == SEQ_IDLE |=> state == SEQ_PREFETCH)
        else begin
            error_count++;
            $display("Fail t=%0t state expected=%0d actual=%0d",
                     $time, SEQ_PREFETCH, $sampled(state));
        end

    a_prefetch_step: assert property (@(posedge clk) disable iff (rst)
        step && state == SEQ_PREFETCH |=> state == SEQ_EXEC)
        else begin
            error_count++;
            $display("Fail t=%0t state expected=%0d actual=%0d",
                     $time, SEQ_EXEC, $sampled(state));
        end

    a_exec_step: assert property (@(posedge clk) disable iff (rst)
        step && state == SEQ_EXEC |=> state == SEQ_EXEC)
        else begin
            error_count++;
            $display("Fail t=%0t state expected=%0d actual=%0d",
                     $time, SEQ_EXEC, $sampled(state));
        end

    a_pc_advance: assert property (@(posedge clk) disable iff (rst)
        step |=> pc == PC_W'(pc_prev + 1'b1))
        else begin
            error_count++;
            $display("Fail t=%0t pc expected=%0d actual=%0d",
                     $time, PC_W'($sampled(pc_prev) + 1'b1), $sampled(pc));
        end

    a_hold_state: assert property (@(posedge clk) disable iff (rst)
        !step |=> state == state_prev)
        else begin
            error_count++;
            $display("Fail t=%0t state expected=%0d actual=%0d",
                     $time, $sampled(state_prev), $sampled(state));
        end

    a_hold_pc: assert property (@(posedge clk) disable iff (rst)
        !step |=> pc == pc_prev)
        else begin
            error_count++;
            $display("Fail t=%0t pc expected=%0d actual=%0d",
                     $time, $sampled(pc_prev), $sampled(pc));
        end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic instr_t make_instr(input logic [6:0] flags, input logic clr,
                                          input logic [4:0] lane, input logic [7:0] imm);
        instr_t w;
        w = '0;
        {w.load_left, w.load_top, w.swap_left, w.swap_top,
         w.shift_right, w.shift_down, w.acc_en} = flags;
        w.acc_clr = clr;
        w.lane    = lane;
        w.imm     = {5'b0, imm};
        return w;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("Fail t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
        end
    endtask

    task automatic clear_model();
        lsel = 1'b0;
        tsel = 1'b0;
        for (int i = 0; i < N; i++) begin
            lbank[0][i] = '0;
            lbank[1][i] = '0;
            tbank[0][i] = '0;
            tbank[1][i] = '0;
            for (int j = 0; j < N; j++) begin
                mr[i][j] = '0;
                mb[i][j] = '0;
                macc[i*N+j] = 0;
            end
        end
    endtask

    // One executed instruction; the array sees the buffers as they were before it
    task automatic model_exec(input instr_t w);
        logic [DATA_W-1:0] left_in;
        logic [DATA_W-1:0] top_in;
        logic [DATA_W-1:0] nr [N][N];
        logic [DATA_W-1:0] nb [N][N];
        byte               sl;
        byte               st;
        int                lane;
        lane = w.lane % N;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (j == 0) left_in = lbank[lsel][i];
                else left_in = mr[i][j-1];
                if (i == 0) top_in = tbank[tsel][j];
                else top_in = mb[i-1][j];
                sl = left_in;
                st = top_in;
                if (w.acc_clr) macc[i*N+j] = 0;
                else if (w.acc_en) macc[i*N+j] += sl * st;
                nr[i][j] = w.shift_right ? left_in : mr[i][j];
                nb[i][j] = w.shift_down ? top_in : mb[i][j];
            end
        end
        mr = nr;
        mb = nb;
        // Loads go to the hidden bank
        if (w.load_left) lbank[!lsel][lane] = w.imm[DATA_W-1:0];
        if (w.swap_left) lsel = !lsel;
        if (w.load_top) tbank[!tsel][lane] = w.imm[DATA_W-1:0];
        if (w.swap_top) tsel = !tsel;
    endtask

    task automatic reset_dut();
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        clear_model();
    endtask

    // 8N1 frame sent LSB first
    task automatic send_byte(input logic [7:0] data);
        uart_rx <= 1'b0;
        repeat (BIT_CYC) @(posedge clk);
        for (int b = 0; b < 8; b++) begin
            uart_rx <= data[b];
            repeat (BIT_CYC) @(posedge clk);
        end
        uart_rx <= 1'b1;
        repeat (BIT_CYC) @(posedge clk);
    endtask

    task automatic wait_stored(input int words);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (int'(dut.u_store.wr_addr) != words && cycles < STORE_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (int'(dut.u_store.wr_addr) != words) begin
            error_count++;
            $display("Instruction store did not take %0d words in time", words);
        end
        @(posedge clk);
    endtask

    task automatic load_program();
        foreach (prog[k]) begin
            for (int b = 3; b >= 0; b--) begin
                send_byte(prog[k][b*8 +: 8]);
            end
        end
        wait_stored(prog.size());
    endtask

    // Step number s; word s-2 is current afterwards and word s-3 has executed
    task automatic advance(input int s);
        step <= 1'b1;
        @(posedge clk);
        step <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (s >= 2 && s - 2 < prog.size()) expect_eq("curr_instr", prog[s-2], curr_instr);
        if (s >= 3 && s - 3 < prog.size()) model_exec(prog[s-3]);
        @(posedge clk);
    endtask

    task automatic read_acc(input int idx, input int expected);
        acc_sel <= SEL_W'(idx);
        @(negedge clk);
        check_count++;
        assert ($signed(acc_out) == expected) else begin
            error_count++;
            $display("Fail t=%0t acc_out[%0d] expected=%0d actual=%0d",
                     $time, idx, expected, $signed(acc_out));
        end
        @(posedge clk);
    endtask

    task automatic compare_all_accs();
        for (int i = 0; i < N * N; i++) begin
            read_acc(i, macc[i]);
        end
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial begin
        logic [31:0] r;
        error_count = 0;
        check_count = 0;
        seed        = 16;
        rst         = 1'b1;
        uart_rx     = 1'b1;
        step        = 1'b0;
        acc_sel     = '0;

        // Directed program with product, hidden load, clear and repeated accumulate
        reset_dut();
        @(negedge clk);
        expect_eq("state", SEQ_IDLE, state);
        expect_eq("pc", 0, pc);
        expect_eq("curr_instr", 0, curr_instr);
        @(posedge clk);
        prog.delete();
        prog.push_back(make_instr(FL_LOAD_L, 1'b0, 5'd0, 8'(A_LEFT)));
        prog.push_back(make_instr(FL_LOAD_T, 1'b0, 5'd0, 8'(A_TOP)));
        prog.push_back(make_instr(FL_SWAP, 1'b0, 5'd0, 8'h00));
        prog.push_back(make_instr(FL_ACC, 1'b0, 5'd0, 8'h00));
        prog.push_back(make_instr(FL_LOAD_L, 1'b0, 5'd0, 8'h05));
        prog.push_back(make_instr(FL_ACC, 1'b0, 5'd0, 8'h00));
        prog.push_back(make_instr(7'b0, 1'b1, 5'd0, 8'h00));
        repeat (3) prog.push_back(make_instr(FL_ACC, 1'b0, 5'd0, 8'h00));
        repeat (2) prog.push_back('0);
        load_program();

        for (int s = 1; s <= prog.size() + 1; s++) begin
            advance(s);
            if (s == 1 || s == 2) begin
                @(negedge clk);
                expect_eq("state", (s == 1) ? SEQ_PREFETCH : SEQ_EXEC, state);
                expect_eq("pc", s, pc);
                @(posedge clk);
            end
            if (s == 6 || s == 9) begin
                for (int i = 0; i < N * N; i++) begin
                    read_acc(i, (s == 6 && i == 0) ? A_PROD : 0);
                end
            end
            if (s == 8) read_acc(0, 2 * A_PROD);
            if (s == 12) begin
                read_acc(0, 3 * A_PROD);
                compare_all_accs();
            end
        end

        // Random program over every lane
        reset_dut();
        prog.delete();
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            prog.push_back(make_instr(FL_LOAD_L, 1'b0, 5'(i), r[7:0]));
            prog.push_back(make_instr(FL_LOAD_T, 1'b0, 5'(i), r[15:8]));
        end
        prog.push_back(make_instr(FL_SWAP, 1'b0, 5'd0, 8'h00));
        for (int k = 0; k < 16; k++) begin
            instr_t w;
            r = $random(seed);
            w = make_instr(r[6:0], r[10:8] == 3'd0, r[15:11], r[23:16]);
            // Reserved fields carry junk that must be ignored
            w.reserved_hi = r[26:24];
            w.reserved_lo = r[29:27];
            w.imm[12:8]   = {3'b0, r[31:30]};
            prog.push_back(w);
        end
        prog.push_back(make_instr(FL_SHIFT | FL_ACC, 1'b0, 5'd0, 8'h00));
        repeat (2) prog.push_back('0);
        load_program();
        for (int s = 1; s <= prog.size() + 1; s++) begin
            advance(s);
        end
        compare_all_accs();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
systolic_pkg.sv
uart_bit_timer.sv
uart_rx.sv
instr_store.sv
step_sequencer.sv
operand_buffer.sv
mac_cell.sv
mac_array.sv
systolic_top.sv
tb_systolic_top.sv
